// ==== design/mpmc_arbiter.sv ====
module mpmc_arbiter
	import mpmc_wb_pkg::*;
#(
	parameter int NUM_CH = 4
)
(
	input logic mem_ui_clk,
	input logic mem_ui_rst,
	input wb_req_t ch_req [NUM_CH],
	input logic gnt_release,
	output logic gnt_valid,
	output ch_id_t gnt_ch,
	output wb_req_t gnt_req
);

	ch_id_t last_ch;
	logic pick_valid;
	ch_id_t pick_ch;
	wb_req_t pick_req;

	// Search upward from the channel after the last one served
	always_comb
	begin
		int idx;
		pick_valid = 1'b0;
		pick_ch = '0;
		pick_req = '0;
		for (int i = 1; i <= NUM_CH; i++)
		begin
			idx = (int'(last_ch) + i) % NUM_CH;
			if (!pick_valid && ch_req[idx].cyc && ch_req[idx].stb)
			begin
				pick_valid = 1'b1;
				pick_ch = ch_id_t'(idx);
				pick_req = ch_req[idx];
			end
		end
	end

	// Grant and pointer
	always_ff @(posedge mem_ui_clk)
	begin
		if (mem_ui_rst)
		begin
			gnt_valid <= 1'b0;
			last_ch <= ch_id_t'(NUM_CH - 1);
		end
		else if (gnt_valid)
		begin
			if (gnt_release)
				gnt_valid <= 1'b0;
		end
		else if (pick_valid)
		begin
			gnt_valid <= 1'b1;
			last_ch <= pick_ch;
		end
	end

	// Request snapshot stays put while the grant is held
	always_ff @(posedge mem_ui_clk)
	begin
		if (!gnt_valid && pick_valid)
		begin
			gnt_ch <= pick_ch;
			gnt_req <= pick_req;
		end
	end

endmodule

// ==== design/mpmc_data_path.sv ====
module mpmc_data_path
	import mpmc_wb_pkg::*;
	import mpmc_mem_pkg::*;
(
	input logic mem_ui_clk,
	input logic mem_ui_rst,
	input wb_req_t gnt_req,
	input seq_state_e state,
	input mem_data_t app_rd_data,
	input logic app_rd_data_valid,
	output mem_data_t rd_word,
	output mem_data_t app_wdf_data,
	output mem_mask_t app_wdf_mask
);

	mem_data_t amo_calc;
	mem_data_t amo_result;
	logic use_result;

	// Only one read is ever outstanding
	always_ff @(posedge mem_ui_clk)
	begin
		if (app_rd_data_valid)
			rd_word <= app_rd_data;
	end

	// ==============================
	// Atomic unit
	// ==============================

	always_comb
	begin
		case (gnt_req.cmd)
			CMD_ADD:  amo_calc = rd_word + gnt_req.dat;
			CMD_AND:  amo_calc = rd_word & gnt_req.dat;
			CMD_OR:   amo_calc = rd_word | gnt_req.dat;
			CMD_EOR:  amo_calc = rd_word ^ gnt_req.dat;
			// Unsigned compare across all 128 bits
			CMD_MINU: amo_calc = (rd_word < gnt_req.dat) ? rd_word : gnt_req.dat;
			CMD_MAXU: amo_calc = (rd_word > gnt_req.dat) ? rd_word : gnt_req.dat;
			default:  amo_calc = rd_word;
		endcase
	end

	always_ff @(posedge mem_ui_clk)
	begin
		if (state == AMO_CALC)
			amo_result <= amo_calc;
	end

	// Marks that the write phase belongs to an atomic
	always_ff @(posedge mem_ui_clk)
	begin
		if (mem_ui_rst)
			use_result <= 1'b0;
		else if (state == AMO_CALC)
			use_result <= 1'b1;
		else if (state == IDLE)
			use_result <= 1'b0;
	end

	// ==============================
	// Write data and mask
	// ==============================

	// Atomics rewrite the whole word
	assign app_wdf_data = use_result ? amo_result : gnt_req.dat;
	assign app_wdf_mask = use_result ? '0 : ~gnt_req.sel;

endmodule

// ==== design/mpmc_mem_pkg.sv ====
package mpmc_mem_pkg;

	// ==============================
	// Application port types
	// ==============================

	typedef logic [28:0] app_addr_t;
	typedef logic [127:0] mem_data_t;

	// A set bit keeps the byte unwritten
	typedef logic [15:0] mem_mask_t;

	typedef enum logic [2:0] {
		MEM_WRITE = 3'd0,
		MEM_READ  = 3'd1
	} mem_cmd_e;

	// ==============================
	// Sequencer states
	// ==============================

	typedef enum logic [2:0] {
		IDLE,
		WRITE_DATA,
		WRITE_CMD,
		READ_CMD,
		READ_WAIT,
		AMO_CALC,
		RESP
	} seq_state_e;

endpackage

// ==== design/mpmc_resp_router.sv ====
module mpmc_resp_router
	import mpmc_wb_pkg::*;
	import mpmc_mem_pkg::*;
#(
	parameter int NUM_CH = 4
)
(
	input logic mem_ui_clk,
	input logic mem_ui_rst,
	input logic done,
	input ch_id_t gnt_ch,
	input mem_data_t rd_word,
	output wb_resp_t ch_resp [NUM_CH]
);

	logic [NUM_CH-1:0] ack_r;

	// Ack only the granted channel, one cycle after done
	always_ff @(posedge mem_ui_clk)
	begin
		if (mem_ui_rst)
			ack_r <= '0;
		else
		begin
			for (int i = 0; i < NUM_CH; i++)
				ack_r[i] <= done && (gnt_ch == ch_id_t'(i));
		end
	end

	// Read word or old atomic value, meaningless after a write
	always_comb
	begin
		for (int i = 0; i < NUM_CH; i++)
		begin
			ch_resp[i].ack = ack_r[i];
			ch_resp[i].dat = rd_word;
		end
	end

endmodule

// ==== design/mpmc_sequencer.sv ====
module mpmc_sequencer
	import mpmc_wb_pkg::*;
	import mpmc_mem_pkg::*;
(
	input logic mem_ui_clk,
	input logic mem_ui_rst,
	input logic gnt_valid,
	input wb_req_t gnt_req,
	input logic app_rdy,
	input logic app_wdf_rdy,
	input logic app_rd_data_valid,
	output logic app_en,
	output logic app_wdf_wren,
	output logic app_wdf_end,
	output mem_cmd_e app_cmd,
	output app_addr_t app_addr,
	output seq_state_e state,
	output logic done,
	output logic gnt_release
);

	logic is_amo;
	logic is_write;
	seq_state_e state_nxt;

	// Atomics always start with a read, whatever we says
	assign is_amo = (gnt_req.cmd != CMD_RW);
	assign is_write = gnt_req.we && !is_amo;

	// ==============================
	// State machine
	// ==============================

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
			begin
				if (gnt_valid)
					state_nxt = is_write ? WRITE_DATA : READ_CMD;
			end
			READ_CMD:
			begin
				if (app_rdy)
					state_nxt = READ_WAIT;
			end
			READ_WAIT:
			begin
				if (app_rd_data_valid)
					state_nxt = is_amo ? AMO_CALC : RESP;
			end
			// Single cycle for the result register
			AMO_CALC:
				state_nxt = WRITE_DATA;
			WRITE_DATA:
			begin
				if (app_wdf_rdy)
					state_nxt = WRITE_CMD;
			end
			WRITE_CMD:
			begin
				if (app_rdy)
					state_nxt = RESP;
			end
			RESP:
				state_nxt = IDLE;
			default:
				state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge mem_ui_clk)
	begin
		if (mem_ui_rst)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// ==============================
	// Application port
	// ==============================

	// Outputs follow the state, so they hold while the port stalls
	assign app_en = (state == READ_CMD) || (state == WRITE_CMD);
	assign app_cmd = (state == WRITE_CMD) ? MEM_WRITE : MEM_READ;

	// One 128-bit word per access
	assign app_addr = {gnt_req.adr[28:4], 4'h0};

	// Single beat, so every write beat is also the last one
	assign app_wdf_wren = (state == WRITE_DATA);
	assign app_wdf_end = (state == WRITE_DATA);

	// Completion on the last edge of the memory access
	assign done = ((state == READ_WAIT) && app_rd_data_valid && !is_amo) ||
		((state == WRITE_CMD) && app_rdy);

	assign gnt_release = (state == RESP);

endmodule

// ==== design/mpmc_top.sv ====
module mpmc_top
	import mpmc_wb_pkg::*;
	import mpmc_mem_pkg::*;
#(
	parameter int NUM_CH = 4
)
(
	input logic mem_ui_clk,
	input logic mem_ui_rst,
	input wb_req_t ch_req [NUM_CH],
	output wb_resp_t ch_resp [NUM_CH],
	output logic app_en,
	output mem_cmd_e app_cmd,
	output app_addr_t app_addr,
	input logic app_rdy,
	output mem_data_t app_wdf_data,
	output mem_mask_t app_wdf_mask,
	output logic app_wdf_wren,
	output logic app_wdf_end,
	input logic app_wdf_rdy,
	input mem_data_t app_rd_data,
	input logic app_rd_data_valid
);

	logic gnt_valid;
	ch_id_t gnt_ch;
	wb_req_t gnt_req;
	logic gnt_release;
	seq_state_e state;
	logic done;
	mem_data_t rd_word;

	mpmc_arbiter #(
		.NUM_CH(NUM_CH)
	) arbiter_i (
		.mem_ui_clk(mem_ui_clk),
		.mem_ui_rst(mem_ui_rst),
		.ch_req(ch_req),
		.gnt_release(gnt_release),
		.gnt_valid(gnt_valid),
		.gnt_ch(gnt_ch),
		.gnt_req(gnt_req)
	);

	// Sequencer and data path work on the same held grant
	mpmc_sequencer sequencer_i (
		.mem_ui_clk(mem_ui_clk),
		.mem_ui_rst(mem_ui_rst),
		.gnt_valid(gnt_valid),
		.gnt_req(gnt_req),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd_data_valid(app_rd_data_valid),
		.app_en(app_en),
		.app_wdf_wren(app_wdf_wren),
		.app_wdf_end(app_wdf_end),
		.app_cmd(app_cmd),
		.app_addr(app_addr),
		.state(state),
		.done(done),
		.gnt_release(gnt_release)
	);

	mpmc_data_path data_path_i (
		.mem_ui_clk(mem_ui_clk),
		.mem_ui_rst(mem_ui_rst),
		.gnt_req(gnt_req),
		.state(state),
		.app_rd_data(app_rd_data),
		.app_rd_data_valid(app_rd_data_valid),
		.rd_word(rd_word),
		.app_wdf_data(app_wdf_data),
		.app_wdf_mask(app_wdf_mask)
	);

	mpmc_resp_router #(
		.NUM_CH(NUM_CH)
	) resp_router_i (
		.mem_ui_clk(mem_ui_clk),
		.mem_ui_rst(mem_ui_rst),
		.done(done),
		.gnt_ch(gnt_ch),
		.rd_word(rd_word),
		.ch_resp(ch_resp)
	);

endmodule

// ==== design/mpmc_wb_pkg.sv ====
package mpmc_wb_pkg;

	// ==============================
	// Channel widths
	// ==============================

	typedef logic [31:0] wb_adr_t;
	typedef logic [127:0] wb_data_t;
	typedef logic [15:0] wb_sel_t;

	// Up to eight channels
	typedef logic [2:0] ch_id_t;

	// Atomic commands operate on the full 128-bit word
	typedef enum logic [3:0] {
		CMD_RW   = 4'd0,
		CMD_ADD  = 4'd1,
		CMD_AND  = 4'd2,
		CMD_OR   = 4'd3,
		CMD_EOR  = 4'd4,
		CMD_MINU = 4'd5,
		CMD_MAXU = 4'd6
	} amo_op_e;

	// ==============================
	// Channel request and response
	// ==============================

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_sel_t sel;
		wb_adr_t adr;
		wb_data_t dat;
		amo_op_e cmd;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		wb_data_t dat;
	} wb_resp_t;

endpackage

// ==== filelist.f ====
design/mpmc_wb_pkg.sv
design/mpmc_mem_pkg.sv
design/mpmc_arbiter.sv
design/mpmc_sequencer.sv
design/mpmc_data_path.sv
design/mpmc_resp_router.sv
design/mpmc_top.sv
tests/mpmc_mem_model.sv
tests/mpmc_checker.sv
tests/tb_mpmc.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the simulation with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_mpmc \
	-f filelist.f -o sim_mpmc &&
./obj_dir/sim_mpmc | tee /dev/stderr | grep -q "^TB PASSED$" &&
echo "run.sh: simulation ok" ||
{
	echo "run.sh: simulation did not pass"
	exit 1
}

// ==== tests/mpmc_checker.sv ====
module mpmc_checker
	import mpmc_wb_pkg::*;
	import mpmc_mem_pkg::*;
#(
	parameter int NUM_CH = 4
)
(
	input logic mem_ui_clk,
	input logic mem_ui_rst,
	input logic app_en,
	input mem_cmd_e app_cmd,
	input app_addr_t app_addr,
	input logic app_rdy,
	input logic app_wdf_wren,
	input mem_data_t app_wdf_data,
	input mem_mask_t app_wdf_mask,
	input logic app_wdf_rdy,
	input wb_resp_t ch_resp [NUM_CH]
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [NUM_CH-1:0] acks;

	always_comb
	begin
		for (int i = 0; i < NUM_CH; i++)
			acks[i] = ch_resp[i].ack;
	end

	cmd_hold: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		app_en && !app_rdy |=> app_en && $stable(app_cmd) && $stable(app_addr))
		else $error("command changed while app_rdy was low");

	wdf_hold: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		app_wdf_wren && !app_wdf_rdy |=>
		app_wdf_wren && $stable(app_wdf_data) && $stable(app_wdf_mask))
		else $error("write data changed while app_wdf_rdy was low");

	// One ack at a time, and never in two cycles back to back
	one_ack: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		$onehot0({acks, $past(acks)}))
		else $error("more than one ack within two cycles");

endmodule

// ==== tests/mpmc_mem_model.sv ====
module mpmc_mem_model
	import mpmc_mem_pkg::*;
(
	input logic mem_ui_clk,
	input logic mem_ui_rst,
	input logic stall,
	input logic app_en,
	input mem_cmd_e app_cmd,
	input app_addr_t app_addr,
	output logic app_rdy,
	input mem_data_t app_wdf_data,
	input mem_mask_t app_wdf_mask,
	input logic app_wdf_wren,
	input logic app_wdf_end,
	output logic app_wdf_rdy,
	output mem_data_t app_rd_data,
	output logic app_rd_data_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	mem_data_t mem [256];
	mem_data_t wdf_data_q;
	mem_mask_t wdf_mask_q;
	logic [7:0] rd_idx;
	int rd_cnt;
	int seed = 32'h47b5;
	logic [31:0] r;

	// Fill pattern built from the whole word index
	initial
	begin
		for (int i = 0; i < 256; i++)
			mem[i] = {32'(i) * 32'h9e37_79b9, ~32'(i), 32'(i) ^ 32'h5a5a_0f0f, 32'(i) + 32'h100};
	end

	always @(posedge mem_ui_clk)
	begin
		r = $random(seed);
		app_rd_data_valid <= 1'b0;
		if (mem_ui_rst)
		begin
			app_rdy <= 1'b0;
			app_wdf_rdy <= 1'b0;
			rd_cnt <= 0;
		end
		else
		begin
			app_rdy <= stall ? r[0] : 1'b1;
			app_wdf_rdy <= stall ? r[1] : 1'b1;
			if (rd_cnt != 0)
			begin
				rd_cnt <= rd_cnt - 1;
				if (rd_cnt == 1)
				begin
					app_rd_data_valid <= 1'b1;
					app_rd_data <= mem[rd_idx];
				end
			end
			if (app_wdf_wren && app_wdf_end && app_wdf_rdy)
			begin
				wdf_data_q <= app_wdf_data;
				wdf_mask_q <= app_wdf_mask;
			end
			if (app_en && app_rdy && app_cmd == MEM_READ)
			begin
				rd_idx <= app_addr[11:4];
				// Latency of 2 to 5 cycles
				rd_cnt <= 2 + int'(r[5:4]);
			end
			if (app_en && app_rdy && app_cmd == MEM_WRITE)
			begin
				for (int b = 0; b < 16; b++)
					if (!wdf_mask_q[b])
						mem[app_addr[11:4]][b*8 +: 8] <= wdf_data_q[b*8 +: 8];
			end
		end
	end

endmodule

// ==== tests/tb_mpmc.sv ====
module tb_mpmc
	import mpmc_wb_pkg::*;
	import mpmc_mem_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_CH = 4;
	localparam int TIMEOUT = 300;

	logic mem_ui_clk;
	logic mem_ui_rst;
	logic stall;
	wb_req_t ch_req [NUM_CH];
	wb_resp_t ch_resp [NUM_CH];
	logic app_en;
	mem_cmd_e app_cmd;
	app_addr_t app_addr;
	logic app_rdy;
	mem_data_t app_wdf_data;
	mem_mask_t app_wdf_mask;
	logic app_wdf_wren;
	logic app_wdf_end;
	logic app_wdf_rdy;
	mem_data_t app_rd_data;
	logic app_rd_data_valid;

	mem_data_t shadow [256];
	int seed = 32'h47b5;

	mpmc_top #(.NUM_CH(NUM_CH)) dut_i (.*);

	mpmc_mem_model mem_i (.*);

	bind mpmc_top mpmc_checker #(.NUM_CH(NUM_CH)) checker_i (
		.mem_ui_clk(mem_ui_clk), .mem_ui_rst(mem_ui_rst), .app_en(app_en),
		.app_cmd(app_cmd), .app_addr(app_addr), .app_rdy(app_rdy),
		.app_wdf_wren(app_wdf_wren), .app_wdf_data(app_wdf_data),
		.app_wdf_mask(app_wdf_mask), .app_wdf_rdy(app_wdf_rdy), .ch_resp(ch_resp)
	);

	initial
	begin
		mem_ui_clk = 1'b0;
		forever
			#4 mem_ui_clk = ~mem_ui_clk;
	end

	// ==============================
	// Reporting and prediction
	// ==============================

	task automatic fail(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp)
			fail($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	function automatic mem_data_t amo_apply(amo_op_e op, mem_data_t old, mem_data_t opnd);
		case (op)
			CMD_ADD:  return old + opnd;
			CMD_AND:  return old & opnd;
			CMD_OR:   return old | opnd;
			CMD_EOR:  return old ^ opnd;
			CMD_MINU: return (opnd < old) ? opnd : old;
			CMD_MAXU: return (opnd > old) ? opnd : old;
			default:  return old;
		endcase
	endfunction

	function automatic mem_data_t merge_bytes(mem_data_t old, mem_data_t dat, wb_sel_t sel);
		mem_data_t res;
		res = old;
		for (int b = 0; b < 16; b++)
			if (sel[b])
				res[b*8 +: 8] = dat[b*8 +: 8];
		return res;
	endfunction

	// ==============================
	// Channel tasks
	// ==============================

	task automatic set_req(input int ch, input logic we, input amo_op_e cmd, input int idx,
		input wb_sel_t sel, input wb_data_t dat);
		wb_req_t r;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		r.we = we;
		r.sel = sel;
		r.adr = wb_adr_t'(idx) << 4;
		r.dat = dat;
		r.cmd = cmd;
		ch_req[ch] <= r;
	endtask

	task automatic wait_ack(input int ch, output wb_data_t rdata);
		int cycles;
		cycles = 0;
		@(negedge mem_ui_clk);
		while (!ch_resp[ch].ack)
		begin
			for (int j = 0; j < NUM_CH; j++)
				if (ch_resp[j].ack)
					fail($sformatf("ack on channel %0d while waiting for channel %0d", j, ch));
			cycles++;
			if (cycles > TIMEOUT)
				fail($sformatf("timeout waiting for ack on channel %0d", ch));
			@(negedge mem_ui_clk);
		end
		rdata = ch_resp[ch].dat;
		@(posedge mem_ui_clk);
		ch_req[ch] <= '0;
	endtask

	task automatic write_word(input int ch, input int idx, input wb_sel_t sel,
		input wb_data_t dat);
		wb_data_t rdata;
		@(posedge mem_ui_clk);
		set_req(ch, 1'b1, CMD_RW, idx, sel, dat);
		wait_ack(ch, rdata);
		shadow[idx] = merge_bytes(shadow[idx], dat, sel);
	endtask

	task automatic read_check(input int ch, input int idx);
		wb_data_t rdata;
		@(posedge mem_ui_clk);
		set_req(ch, 1'b0, CMD_RW, idx, '1, '0);
		wait_ack(ch, rdata);
		check_value($sformatf("ch_resp[%0d].dat", ch), rdata, shadow[idx]);
	endtask

	task automatic amo_check(input int ch, input amo_op_e op, input int idx,
		input wb_data_t dat);
		wb_data_t rdata;
		@(posedge mem_ui_clk);
		set_req(ch, 1'b0, op, idx, '1, dat);
		wait_ack(ch, rdata);
		check_value($sformatf("ch_resp[%0d].dat old", ch), rdata, shadow[idx]);
		shadow[idx] = amo_apply(op, shadow[idx], dat);
	endtask

	function automatic wb_data_t rand_word();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	// ==============================
	// Directed tests
	// ==============================

	task automatic test_reset();
		@(negedge mem_ui_clk);
		check_value("app_en", app_en, 1'b0);
		check_value("app_wdf_wren", app_wdf_wren, 1'b0);
		check_value("app_wdf_end", app_wdf_end, 1'b0);
		for (int i = 0; i < NUM_CH; i++)
			check_value($sformatf("ch_resp[%0d].ack", i), ch_resp[i].ack, 1'b0);
	endtask

	task automatic test_write_read();
		for (int ch = 0; ch < NUM_CH; ch++)
		begin
			write_word(ch, 8 + ch, '1, rand_word());
			read_check(ch, 8 + ch);
		end
	endtask

	task automatic test_partial();
		write_word(1, 20, 16'h00f0, rand_word());
		write_word(2, 20, 16'h8001, rand_word());
		read_check(3, 20);
	endtask

	task automatic test_atomics();
		amo_op_e ops [6] = '{CMD_ADD, CMD_AND, CMD_OR, CMD_EOR, CMD_MINU, CMD_MAXU};
		for (int k = 0; k < 6; k++)
		begin
			amo_check(k % NUM_CH, ops[k], 30 + k, rand_word());
			read_check((k + 1) % NUM_CH, 30 + k);
		end
	endtask

	task automatic round(input int order [NUM_CH]);
		wb_data_t rdata;
		for (int k = 0; k < NUM_CH; k++)
		begin
			wait_ack(order[k], rdata);
			shadow[40 + order[k]] = {4{32'h1000 + 32'(order[k])}};
		end
		for (int ch = 0; ch < NUM_CH; ch++)
			read_check(ch, 40 + ch);
	endtask

	task automatic test_round_robin();
		// Channel 3 served last, so the search restarts at channel 0
		read_check(3, 43);
		@(posedge mem_ui_clk);
		for (int ch = 0; ch < NUM_CH; ch++)
			set_req(ch, 1'b1, CMD_RW, 40 + ch, '1, {4{32'h1000 + 32'(ch)}});
		round('{0, 1, 2, 3});
		// Channel 2 first, the rest join while it is served
		@(posedge mem_ui_clk);
		set_req(2, 1'b1, CMD_RW, 42, '1, {4{32'h1002}});
		@(posedge mem_ui_clk);
		set_req(0, 1'b1, CMD_RW, 40, '1, {4{32'h1000}});
		set_req(1, 1'b1, CMD_RW, 41, '1, {4{32'h1001}});
		set_req(3, 1'b1, CMD_RW, 43, '1, {4{32'h1003}});
		round('{2, 3, 0, 1});
	endtask

	task automatic test_backpressure();
		logic [31:0] r;
		int ch;
		int idx;
		stall <= 1'b1;
		for (int n = 0; n < 60; n++)
		begin
			r = $random(seed);
			ch = int'(r[11:10]);
			idx = 64 + int'(r[3:0]);
			if (r[6:4] < 3)
				read_check(ch, idx);
			else if (r[6:4] < 5)
				write_word(ch, idx, r[31:16], rand_word());
			else
				amo_check(ch, amo_op_e'(1 + int'(r[9:7]) % 6), idx, rand_word());
		end
		stall <= 1'b0;
	endtask

	initial
	begin
		for (int i = 0; i < 256; i++)
			shadow[i] = {32'(i) * 32'h9e37_79b9, ~32'(i), 32'(i) ^ 32'h5a5a_0f0f, 32'(i) + 32'h100};
		mem_ui_rst = 1'b1;
		stall = 1'b0;
		for (int i = 0; i < NUM_CH; i++)
			ch_req[i] = '0;
		repeat (4) @(posedge mem_ui_clk);
		mem_ui_rst <= 1'b0;
		test_reset();
		test_write_read();
		test_partial();
		test_atomics();
		test_round_robin();
		test_backpressure();
		$display("TB PASSED");
		$finish;
	end

endmodule
